// ==== filelist.f ====
hdl/core_pkg.sv
hdl/fetch.sv
hdl/issue.sv
hdl/regfile.sv
hdl/decode.sv
hdl/execute.sv
hdl/core.sv
tests/imem_model.sv
tests/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module core_tb -o core_tb_sim

# The simulator's exit status is lost in the pipe, the log decides
./obj_dir/core_tb_sim | tee sim.log

if grep -q "TB PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== tests/core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_tb;
	import core_pkg::*;

	localparam int    CLK_PERIOD   = 40;
	localparam int    RESET_CYCLES = 10;
	localparam int    IDLE_CYCLES  = 40;
	localparam int    MAX_STEPS    = 1000;
	// Eight runs, each reset + idle + about 20 cycles per instruction, with margin
	localparam int    TIMEOUT_CYCLES = 4000;
	localparam word_t HALT = 32'hEAFF_FFFE;  // B to itself

	logic     clk;
	logic     reset;
	logic     random_wait;
	logic     insn_req;
	word_t    insn_addr;
	logic     insn_wait;
	word_t    insn_data;
	logic     retire_valid;
	reg_num_t retire_reg;
	word_t    retire_data;

	word_t    prog [256];
	int       prog_len;
	reg_num_t exp_reg [$];  // Expected register writes in program order
	word_t    exp_data [$];
	logic     first_seen;
	word_t    first_addr;
	int       cycles;

	core uut (
		.clk, .reset, .insn_req, .insn_addr, .insn_wait, .insn_data,
		.retire_valid, .retire_reg, .retire_data
	);

	imem_model imem (.clk, .random_wait, .insn_req, .insn_addr, .insn_wait, .insn_data);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic compare(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			$display("Mismatch %s: got %h, expected %h", name, got, want);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	always @(posedge clk) begin
		if (cycles >= TIMEOUT_CYCLES)
			abort_run($sformatf("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES));
		else
			cycles++;
	end

	// Sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (!reset) begin
			if (!first_seen && insn_req && !insn_wait) begin
				first_seen = 1'b1;
				first_addr = insn_addr;
			end
			if (retire_valid) begin
				if (exp_reg.size() == 0) begin
					abort_run($sformatf("Unexpected retire of r%0d with value %h",
						retire_reg, retire_data));
				end else begin
					compare("retire_reg", 32'(retire_reg), 32'(exp_reg.pop_front()));
					compare("retire_data", retire_data, exp_data.pop_front());
				end
			end
		end
	end

	function automatic word_t dp_imm(input logic [3:0] op, input reg_num_t rd,
		input reg_num_t rn, input logic [3:0] rot, input logic [7:0] imm);
		return {4'hE, 3'b001, op, 1'b0, rn, rd, rot, imm};
	endfunction

	function automatic word_t dp_reg(input logic [3:0] op, input reg_num_t rd,
		input reg_num_t rn, input reg_num_t rm);
		return {4'hE, 3'b000, op, 1'b0, rn, rd, 8'h00, rm};
	endfunction

	// Word offset counts from two words past the branch
	function automatic word_t branch_to(input int from, input int to);
		int off;
		off = to - from - 2;
		return {4'hE, 3'b101, 1'b0, off[23:0]};
	endfunction

	function automatic word_t ror32(input word_t x, input int n);
		if (n == 0)
			return x;
		return (x >> n) | (x << (32 - n));
	endfunction

	task automatic emit(input word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// Walks the program by the ISA rules until the halt branch
	task automatic interpret_program();
		word_t      regs [16];
		word_t      pc;
		word_t      insn;
		word_t      b;
		word_t      result;
		int         off;
		int         steps;
		logic       known;
		logic       done;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		pc = RESET_PC;
		steps = 0;
		done = 1'b0;
		exp_reg.delete();
		exp_data.delete();
		while (!done && steps < MAX_STEPS) begin
			insn = prog[pc[9:2]];
			if (insn[27:25] == 3'b101 && !insn[24]) begin
				off = $signed(insn[23:0]);
				done = (off == -2);  // Halt
				pc = pc + 8 + off * 4;
			end else begin
				if (insn[27:26] == 2'b00) begin
					b = insn[25] ? ror32({24'b0, insn[7:0]}, 2 * insn[11:8]) : regs[insn[3:0]];
					known = 1'b1;
					case (insn[24:21])
						4'd0:    result = regs[insn[19:16]] & b;
						4'd1:    result = regs[insn[19:16]] ^ b;
						4'd2:    result = regs[insn[19:16]] - b;
						4'd4:    result = regs[insn[19:16]] + b;
						4'd12:   result = regs[insn[19:16]] | b;
						4'd13:   result = b;
						default: known = 1'b0;
					endcase
					if (known) begin
						regs[insn[15:12]] = result;
						exp_reg.push_back(insn[15:12]);
						exp_data.push_back(result);
					end
				end
				pc = pc + 4;
			end
			steps++;
		end
		if (!done)
			abort_run("Reference run never reached the halt branch");
	endtask

	task automatic run_program(input logic use_wait);
		@(posedge clk);
		reset <= 1'b1;
		random_wait <= use_wait;
		@(posedge clk);
		// Unused words are load/store no-ops tagged with their index
		for (int i = 0; i < 256; i++)
			imem.mem[i] = (i < prog_len) ? prog[i] : (32'hE400_0000 | i);
		interpret_program();
		repeat (RESET_CYCLES) @(posedge clk);
		compare("insn_req", 32'(insn_req), 32'h0);
		compare("retire_valid", 32'(retire_valid), 32'h0);
		first_seen = 1'b0;
		reset <= 1'b0;
		while (exp_data.size() != 0)
			@(posedge clk);
		repeat (IDLE_CYCLES) @(posedge clk);  // Nothing extra may retire
		if (!first_seen)
			abort_run("No instruction request was accepted after reset");
		else
			compare("insn_addr", first_addr, RESET_PC);
	endtask

	task automatic build_alu_program();
		prog_len = 0;
		emit(dp_imm(OP_MOV, 4'd1, 4'd0, 4'd0, 8'hFF));
		emit(dp_imm(OP_MOV, 4'd2, 4'd0, 4'd2, 8'hF3));
		emit(dp_imm(OP_ADD, 4'd3, 4'd1, 4'd0, 8'h11));
		emit(dp_imm(OP_SUB, 4'd4, 4'd2, 4'd12, 8'h01));
		emit(dp_imm(OP_AND, 4'd5, 4'd2, 4'd2, 8'hFF));
		emit(dp_imm(OP_EOR, 4'd6, 4'd1, 4'd15, 8'hA5));
		emit(dp_imm(OP_ORR, 4'd7, 4'd3, 4'd8, 8'h80));
		emit(dp_imm(OP_MOV, 4'd15, 4'd9, 4'd1, 8'h7E));  // Rn ignored, r15 plain
		emit(dp_imm(OP_SUB, 4'd8, 4'd0, 4'd0, 8'h01));
		emit(HALT);
	endtask

	task automatic build_hazard_program();
		prog_len = 0;
		emit(dp_imm(OP_MOV, 4'd1, 4'd0, 4'd0, 8'h05));
		emit(dp_imm(OP_MOV, 4'd2, 4'd0, 4'd0, 8'h03));
		emit(dp_reg(OP_ADD, 4'd3, 4'd1, 4'd2));  // Rm from previous
		emit(dp_reg(OP_SUB, 4'd4, 4'd3, 4'd1));  // Rn from previous
		emit(dp_reg(OP_ADD, 4'd4, 4'd4, 4'd4));
		emit(dp_reg(OP_EOR, 4'd5, 4'd4, 4'd3));
		emit(dp_reg(OP_ORR, 4'd6, 4'd5, 4'd4));
		emit(dp_reg(OP_MOV, 4'd7, 4'd0, 4'd6));
		emit(dp_reg(OP_AND, 4'd8, 4'd7, 4'd5));
		emit(dp_reg(OP_SUB, 4'd9, 4'd8, 4'd7));
		emit(HALT);
	endtask

	task automatic build_branch_program();
		prog_len = 0;
		emit(dp_imm(OP_MOV, 4'd1, 4'd0, 4'd0, 8'h01));
		emit(branch_to(1, 5));
		emit(dp_imm(OP_MOV, 4'd2, 4'd0, 4'd0, 8'h0B));  // Skipped
		emit(dp_imm(OP_ADD, 4'd1, 4'd1, 4'd0, 8'h02));
		emit(branch_to(4, 8));
		emit(dp_imm(OP_ORR, 4'd3, 4'd1, 4'd0, 8'h30));
		emit(branch_to(6, 3));  // Backward
		emit(dp_imm(OP_MOV, 4'd4, 4'd0, 4'd0, 8'h44));  // Skipped
		emit(dp_imm(OP_EOR, 4'd5, 4'd1, 4'd0, 8'hFF));
		emit(HALT);
	endtask

	task automatic build_unsupported_program();
		prog_len = 0;
		emit(dp_imm(OP_MOV, 4'd1, 4'd0, 4'd0, 8'h07));
		emit(dp_reg(4'd10, 4'd1, 4'd1, 4'd2));  // CMP
		emit(32'hE591_2000);  // LDR
		emit(dp_imm(4'd3, 4'd1, 4'd1, 4'd0, 8'h01));  // RSB
		emit(dp_imm(OP_ADD, 4'd2, 4'd1, 4'd0, 8'h01));
		emit({4'hE, 3'b101, 1'b1, 24'h000010});  // BL
		emit(32'hEF00_0000);
		emit(32'hEE01_0F10);
		emit(dp_reg(OP_MOV, 4'd3, 4'd0, 4'd2));
		emit(HALT);
	endtask

	task automatic reset_state_check();
		prog_len = 0;
		emit(HALT);
		run_program(1'b0);
	endtask

	task automatic alu_immediates();
		build_alu_program();
		run_program(1'b0);
	endtask

	task automatic dependent_chain();
		build_hazard_program();
		run_program(1'b0);
	endtask

	task automatic taken_branches();
		build_branch_program();
		run_program(1'b0);
	endtask

	task automatic random_wait_rerun();
		build_alu_program();
		run_program(1'b1);
		build_hazard_program();
		run_program(1'b1);
		build_branch_program();
		run_program(1'b1);
	endtask

	task automatic unsupported_encodings();
		build_unsupported_program();
		run_program(1'b0);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		random_wait = 1'b0;
		cycles = 0;
		first_seen = 1'b0;
		first_addr = '0;
		prog_len = 0;
		void'($urandom(76));
		reset_state_check();
		alu_immediates();
		dependent_chain();
		taken_branches();
		random_wait_rerun();
		unsupported_encodings();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/imem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module imem_model (
	input  logic            clk,
	input  logic            random_wait,
	input  logic            insn_req,
	input  core_pkg::word_t insn_addr,
	output logic            insn_wait,
	output core_pkg::word_t insn_data
);
	import core_pkg::*;

	localparam int DEPTH = 256;

	word_t      mem [DEPTH];  // Loaded by the testbench before each run
	logic [7:0] index;

	assign index = insn_addr[9:2];  // Word index, wraps at DEPTH

	initial begin
		insn_wait = 1'b0;
		insn_data = '0;
	end

	always @(posedge clk) begin
		if (insn_req && !insn_wait)
			insn_data <= mem[index];  // Valid one cycle after acceptance
		if (random_wait)
			insn_wait <= ($urandom_range(3) == 0);  // Roughly one cycle in four
		else
			insn_wait <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== hdl/core.sv ====
`timescale 1ns/10ps
`default_nettype none

module core (
	input  logic               clk,
	input  logic               reset,
	output logic               insn_req,
	output core_pkg::word_t    insn_addr,
	input  logic               insn_wait,
	input  core_pkg::word_t    insn_data,
	output logic               retire_valid,
	output core_pkg::reg_num_t retire_reg,
	output core_pkg::word_t    retire_data
);
	import core_pkg::*;

	logic     bubble_1a;
	word_t    insn_1a;
	word_t    pc_1a;
	logic     stall_0a;
	logic     bubble_2a;
	word_t    insn_2a;
	word_t    pc_2a;
	reg_num_t read_a;
	reg_num_t read_b;
	word_t    rdata_a;
	word_t    rdata_b;
	word_t    op_a_2a;
	word_t    op_b_2a;
	logic     pending_write_2a;
	reg_num_t pending_num_2a;
	logic     jmp;
	word_t    jmppc;
	logic     rf_write;
	reg_num_t rf_write_reg;
	word_t    rf_write_data;

	fetch fetch (
		.clk, .reset, .stall_0a, .jmp, .jmppc,
		.insn_wait, .insn_data, .insn_req, .insn_addr,
		.bubble_1a, .insn_1a, .pc_1a
	);

	issue issue (
		.clk, .reset, .jmp, .bubble_1a, .insn_1a, .pc_1a,
		.pending_write_2a, .pending_num_2a,
		.stall_0a, .bubble_2a, .insn_2a, .pc_2a
	);

	regfile regfile (
		.clk, .reset, .read_a, .read_b, .rdata_a, .rdata_b,
		.write      (rf_write),
		.write_reg  (rf_write_reg),
		.write_data (rf_write_data)
	);

	decode decode (
		.clk, .stall_0a, .insn_1a, .read_a, .read_b,
		.rdata_a, .rdata_b, .op_a_2a, .op_b_2a
	);

	execute execute (
		.clk, .reset, .bubble_2a, .insn_2a, .pc_2a, .op_a_2a, .op_b_2a,
		.pending_write_2a, .pending_num_2a, .jmp, .jmppc,
		.rf_write, .rf_write_reg, .rf_write_data
	);

	// Every regfile write is a retirement
	assign retire_valid = rf_write;
	assign retire_reg   = rf_write_reg;
	assign retire_data  = rf_write_data;

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute (
	input  logic               clk,
	input  logic               reset,
	input  logic               bubble_2a,
	input  core_pkg::word_t    insn_2a,
	input  core_pkg::word_t    pc_2a,
	input  core_pkg::word_t    op_a_2a,
	input  core_pkg::word_t    op_b_2a,
	output logic               pending_write_2a,
	output core_pkg::reg_num_t pending_num_2a,
	output logic               jmp,
	output core_pkg::word_t    jmppc,
	output logic               rf_write,
	output core_pkg::reg_num_t rf_write_reg,
	output core_pkg::word_t    rf_write_data
);
	import core_pkg::*;

	opcode_t opcode_2a;
	logic    known_op;
	logic    is_branch;
	word_t   alu_result;
	word_t   offset;

	assign opcode_2a = opcode_t'(insn_2a[OPC_HI:OPC_LO]);

	always_comb begin
		known_op   = 1'b1;
		alu_result = '0;
		case (opcode_2a)
			OP_AND: alu_result = op_a_2a & op_b_2a;
			OP_EOR: alu_result = op_a_2a ^ op_b_2a;
			OP_SUB: alu_result = op_a_2a - op_b_2a;
			OP_ADD: alu_result = op_a_2a + op_b_2a;
			OP_ORR: alu_result = op_a_2a | op_b_2a;
			OP_MOV: alu_result = op_b_2a;
			default: known_op = 1'b0;  // Compares, RSB and friends
		endcase
	end

	// Only unsupported opcodes fall out here and never write
	assign pending_write_2a = !bubble_2a && is_dp(insn_2a) && known_op;
	assign pending_num_2a   = insn_2a[RD_HI:RD_LO];

	// Plain B only, BL is left as a no-op
	assign is_branch = (insn_2a[CLASS_HI:CLASS_LO] == CLASS_BRANCH) && !insn_2a[LINK_BIT];

	// Sign-extended word offset
	assign offset = {{6{insn_2a[OFF_HI]}}, insn_2a[OFF_HI:OFF_LO], 2'b00};

	assign jmp   = !bubble_2a && is_branch;
	assign jmppc = pc_2a + PC_AHEAD + offset;

	// Writeback register, feeds regfile and retire port
	always_ff @(posedge clk) begin
		if (reset) begin
			rf_write <= 1'b0;
		end else begin
			rf_write <= pending_write_2a;
		end
	end

	always_ff @(posedge clk) begin
		rf_write_reg  <= pending_num_2a;
		rf_write_data <= alu_result;
	end

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode (
	input  logic               clk,
	input  logic               stall_0a,
	input  core_pkg::word_t    insn_1a,
	output core_pkg::reg_num_t read_a,
	output core_pkg::reg_num_t read_b,
	input  core_pkg::word_t    rdata_a,
	input  core_pkg::word_t    rdata_b,
	output core_pkg::word_t    op_a_2a,
	output core_pkg::word_t    op_b_2a
);
	import core_pkg::*;

	logic [4:0]  rot_amount;   // Rotate field times two
	logic [63:0] imm_pair;
	word_t       imm_zext;
	word_t       imm_rot;
	word_t       op_b_1a;

	assign read_a = insn_1a[RN_HI:RN_LO];
	assign read_b = insn_1a[RM_HI:RM_LO];

	assign rot_amount = {insn_1a[ROT_HI:ROT_LO], 1'b0};
	assign imm_zext   = {24'b0, insn_1a[IMM_HI:IMM_LO]};

	// Rotate right by shifting a doubled copy
	assign imm_pair = {imm_zext, imm_zext} >> rot_amount;
	assign imm_rot  = imm_pair[31:0];

	assign op_b_1a = insn_1a[I_BIT] ? imm_rot : rdata_b;

	always_ff @(posedge clk) begin
		if (!stall_0a) begin
			op_a_2a <= rdata_a;
			op_b_2a <= op_b_1a;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile (
	input  logic               clk,
	input  logic               reset,
	input  core_pkg::reg_num_t read_a,
	input  core_pkg::reg_num_t read_b,
	output core_pkg::word_t    rdata_a,
	output core_pkg::word_t    rdata_b,
	input  logic               write,
	input  core_pkg::reg_num_t write_reg,
	input  core_pkg::word_t    write_data
);
	import core_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (write) begin
			regs[write_reg] <= write_data;
		end
	end

	// Write-through so 3a results are seen by 1a without a stall
	assign rdata_a = (write && (write_reg == read_a)) ? write_data : regs[read_a];
	assign rdata_b = (write && (write_reg == read_b)) ? write_data : regs[read_b];

endmodule

`default_nettype wire

// ==== hdl/issue.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue (
	input  logic               clk,
	input  logic               reset,
	input  logic               jmp,
	input  logic               bubble_1a,
	input  core_pkg::word_t    insn_1a,
	input  core_pkg::word_t    pc_1a,
	input  logic               pending_write_2a,
	input  core_pkg::reg_num_t pending_num_2a,
	output logic               stall_0a,
	output logic               bubble_2a,
	output core_pkg::word_t    insn_2a,
	output core_pkg::word_t    pc_2a
);
	import core_pkg::*;

	opcode_t  opcode_1a;
	reg_num_t rn_1a;
	reg_num_t rm_1a;
	logic     dp_1a;
	logic     reads_rn;
	logic     reads_rm;
	logic     rn_hit;
	logic     rm_hit;

	assign opcode_1a = opcode_t'(insn_1a[OPC_HI:OPC_LO]);
	assign rn_1a     = insn_1a[RN_HI:RN_LO];
	assign rm_1a     = insn_1a[RM_HI:RM_LO];
	assign dp_1a     = is_dp(insn_1a);

	// MOV has no first operand
	assign reads_rn = dp_1a && (opcode_1a != OP_MOV);
	assign reads_rm = dp_1a && !insn_1a[I_BIT];

	assign rn_hit = reads_rn && (rn_1a == pending_num_2a);
	assign rm_hit = reads_rm && (rm_1a == pending_num_2a);

	// Result in 2a is not in the regfile yet; one cycle later it is
	// written through from 3a
	assign stall_0a = !bubble_1a && pending_write_2a && (rn_hit || rm_hit);

	always_ff @(posedge clk) begin
		if (reset) begin
			bubble_2a <= 1'b1;
		end else begin
			bubble_2a <= bubble_1a || stall_0a || jmp;  // Hole on hazard or flush
		end
	end

	always_ff @(posedge clk) begin
		insn_2a <= insn_1a;
		pc_2a   <= pc_1a;
	end

endmodule

`default_nettype wire

// ==== hdl/fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch (
	input  logic            clk,
	input  logic            reset,
	input  logic            stall_0a,
	input  logic            jmp,
	input  core_pkg::word_t jmppc,
	input  logic            insn_wait,
	input  core_pkg::word_t insn_data,
	output logic            insn_req,
	output core_pkg::word_t insn_addr,
	output logic            bubble_1a,
	output core_pkg::word_t insn_1a,
	output core_pkg::word_t pc_1a
);
	import core_pkg::*;

	word_t pc;           // Address of the current request
	word_t resp_pc;      // Address of the response arriving now
	word_t held_insn;
	word_t held_pc;
	word_t redir_pc;
	logic  started;
	logic  resp_live;    // Accepted last cycle and not stale
	logic  held_valid;   // 1a word parked in the hold buffer
	logic  was_waiting;  // Request was held off last cycle
	logic  redir;        // Jump seen while request was held off
	logic  accept;
	logic  held_off;

	assign insn_req  = started && (!held_valid || was_waiting);
	assign insn_addr = pc;
	assign accept    = insn_req && !insn_wait;
	assign held_off  = insn_req && insn_wait;

	// Hold buffer has priority, it is always the older word
	assign bubble_1a = !(held_valid || resp_live);
	assign insn_1a   = held_valid ? held_insn : insn_data;
	assign pc_1a     = held_valid ? held_pc : resp_pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc          <= RESET_PC;
			started     <= 1'b0;
			resp_live   <= 1'b0;
			held_valid  <= 1'b0;
			was_waiting <= 1'b0;
			redir       <= 1'b0;
		end else begin
			started     <= 1'b1;
			was_waiting <= held_off;
			resp_live   <= accept && !jmp && !redir;  // Drop words from the old path
			held_valid  <= !jmp && (stall_0a || (held_valid && resp_live));
			if (jmp && held_off) begin
				redir <= 1'b1;  // Address must stay put until accepted
			end else if (jmp) begin
				pc <= jmppc;
			end else if (accept) begin
				pc    <= redir ? redir_pc : pc + 32'd4;
				redir <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			resp_pc <= pc;
		if (jmp)
			redir_pc <= jmppc;
		if (held_valid != stall_0a) begin  // Park a stalled word or refill behind the held one
			held_insn <= insn_data;
			held_pc   <= resp_pc;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;     // Data word or byte address
	typedef logic [3:0]  reg_num_t;  // Architectural register number

	// Data-processing opcode field, only the supported subset
	typedef enum logic [3:0] {
		OP_AND = 4'd0,
		OP_EOR = 4'd1,
		OP_SUB = 4'd2,
		OP_ADD = 4'd4,
		OP_ORR = 4'd12,
		OP_MOV = 4'd13
	} opcode_t;

	localparam int    NUM_REGS = 16;
	localparam word_t RESET_PC = 32'h0000_0000;
	localparam word_t PC_AHEAD = 32'd8;  // Branch base is two words past the branch

	// Instruction class, bits 27:25
	localparam int       CLASS_HI     = 27;
	localparam int       CLASS_LO     = 25;
	localparam logic [2:0] CLASS_DP_REG = 3'b000;
	localparam logic [2:0] CLASS_DP_IMM = 3'b001;
	localparam logic [2:0] CLASS_BRANCH = 3'b101;

	localparam int I_BIT    = 25;  // Immediate second operand
	localparam int LINK_BIT = 24;  // Set for BL, which is not supported

	localparam int OPC_HI = 24;
	localparam int OPC_LO = 21;
	localparam int RN_HI  = 19;
	localparam int RN_LO  = 16;
	localparam int RD_HI  = 15;
	localparam int RD_LO  = 12;
	localparam int ROT_HI = 11;
	localparam int ROT_LO = 8;
	localparam int IMM_HI = 7;
	localparam int IMM_LO = 0;
	localparam int RM_HI  = 3;
	localparam int RM_LO  = 0;
	localparam int OFF_HI = 23;
	localparam int OFF_LO = 0;

	// Both data-processing classes, immediate or register operand
	function automatic logic is_dp(word_t insn);
		return (insn[CLASS_HI:CLASS_LO] == CLASS_DP_REG) ||
			(insn[CLASS_HI:CLASS_LO] == CLASS_DP_IMM);
	endfunction

endpackage

`default_nettype wire
